// File: sources.f
+incdir+sim
design/lg_pkg.sv
design/lg_regs.sv
design/lg_table.sv
design/lg_sequencer.sv
design/lg_pin_lane.sv
design/lg_stream_out.sv
design/lg_top.sv
sim/lg_tb.sv

// File: Bender.yml
package:
  name: lg_pattern_gen

sources:
  - files:
      - design/lg_pkg.sv
      - design/lg_regs.sv
      - design/lg_table.sv
      - design/lg_sequencer.sv
      - design/lg_pin_lane.sv
      - design/lg_stream_out.sv
      - design/lg_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/lg_tb.sv

// File: sim/lg_tb_tasks.svh
// logic generator testbench helpers
// compare tasks, cpu bus access and the model of pointer walk and lanes
`ifndef LG_TB_TASKS_SVH
`define LG_TB_TASKS_SVH

////////////////////
// compare tasks
////////////////////

task automatic check_pins(input string name, input pins_t exp, input pins_t act);
  if (act !== exp) begin
    $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    abort_run("stream data mismatch");
  end
endtask

task automatic check_last(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
    abort_run("last flag mismatch");
  end
endtask

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
  if (act !== exp) begin
    $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    abort_run("readback mismatch");
  end
endtask

////////////////////
// cpu bus
////////////////////

// one cycle request on the falling edge, ack due one cycle later
task automatic bus_op(input bit to_tbl, input bit wr, input logic [lg_aw-1:0] addr,
                      input logic [31:0] wdata, output logic [31:0] rdata);
  cpu_req_t q;
  cpu_rsp_t r;
  q       = '0;
  q.wen   = wr;
  q.ren   = ~wr;
  q.addr  = addr;
  q.wdata = wdata;
  @(negedge bus);
  if (to_tbl) tbl_req = q;
  else        reg_req = q;
  @(negedge bus);
  tbl_req = '0;
  reg_req = '0;
  r = to_tbl ? tbl_rsp : reg_rsp;
  if (r.ack !== 1'b1) abort_run("bus request got no ack one cycle later");
  else                rdata = r.rdata;
endtask

task automatic reg_write(input logic [lg_baw-1:0] a, input logic [31:0] d);
  logic [31:0] rd;
  bus_op(1'b0, 1'b1, lg_aw'(a), d, rd);
endtask

task automatic check_reg(input logic [lg_baw-1:0] a, input logic [31:0] exp);
  logic [31:0] rd;
  bus_op(1'b0, 1'b0, lg_aw'(a), '0, rd);
  check_word($sformatf("reg_rsp.rdata[0x%h]", a), exp, rd);
endtask

task automatic reg_roundtrip(input logic [lg_baw-1:0] a, input logic [31:0] mask);
  logic [31:0] d;
  d = $random(seed);
  reg_write(a, d);
  check_reg(a, d & mask);  // unused bits read zero
endtask

task automatic tbl_write(input int i, input logic [31:0] d);
  logic [31:0] rd;
  bus_op(1'b1, 1'b1, lg_aw'(i), d, rd);
endtask

task automatic tbl_read(input int i, output logic [31:0] d);
  bus_op(1'b1, 1'b0, lg_aw'(i), '0, d);
endtask

////////////////////
// run control
////////////////////

task automatic set_lanes();
  lcfg = $random(seed);
  reg_write(reg_oe0, 32'(lcfg.oe0));
  reg_write(reg_oe1, 32'(lcfg.oe1));
  reg_write(reg_msk, 32'(lcfg.msk));
  reg_write(reg_val, 32'(lcfg.val));
endtask

task automatic load_cfg(input gen_cfg_t c);
  reg_write(reg_mod, {30'd0, c.inf, c.ben});
  reg_write(reg_siz, 32'(c.siz));
  reg_write(reg_off, 32'(c.off));
  reg_write(reg_ste, 32'(c.ste));
  reg_write(reg_bpn, 32'(c.bpn));
endtask

task automatic start_sw();
  reg_write(reg_ctl, 32'h1);  // arm
  reg_write(reg_ctl, 32'h4);  // software trigger
endtask

task automatic pulse_trg(input logic [lg_tn-1:0] t);
  @(negedge bus);
  trg = t;
  @(negedge bus);
  trg = '0;
endtask

task automatic idle_cycles(input int n);
  repeat (n) @(posedge bus);
endtask

// counters move on the falling edge, looked at on the rising edge
task automatic wait_beats(input int n);
  int target;
  target = n_acc + n;
  do @(posedge bus); while (n_acc < target);
endtask

task automatic wait_drain();
  do @(posedge bus); while (exp_q.size() != 0);
endtask

task automatic finish_burst(input gen_cfg_t c, input int irq0);
  wait_drain();
  idle_cycles(10);
  if (n_irq - irq0 != 1) begin
    abort_run("irq did not pulse exactly once for the burst");
  end else begin
    check_reg(reg_sbn, 32'(c.bpn));
    check_reg(reg_ctl, 32'h0);     // back to idle
  end
endtask

////////////////////
// model
////////////////////

// pointer plus step, one table size off when it reaches siz
function automatic int step_ptr(input gen_cfg_t c, input int p, output bit pass_end);
  int s;
  s = p + int'(c.ste);
  pass_end = (s >= int'(c.siz));
  return pass_end ? s - int'(c.siz) : s;
endfunction

function automatic pins_t lane_out(input beat_t b, input lane_cfg_t l);
  pins_t p;
  for (int i = 0; i < lg_dn; i++) begin
    p[i].o = l.val ^ (l.msk & b[i]);
    p[i].e = (p[i].o & l.oe1) | (~p[i].o & l.oe0);  // oe1 on ones, oe0 on zeros
  end
  return p;
endfunction

// beats in one finite burst
function automatic int burst_len(input gen_cfg_t c);
  int p;
  int passes;
  int n;
  bit pass_end;
  p      = c.off;
  passes = 0;
  n      = 0;
  while (passes < int'(c.bpn)) begin
    p = step_ptr(c, p, pass_end);
    if (pass_end) passes++;
    n++;
  end
  return n;
endfunction

// queue the expected beats, up to n_max or the end of the burst
task automatic predict(input gen_cfg_t c, input int n_max, output int n);
  int p;
  int passes;
  bit pass_end;
  bit fin;
  p      = c.off;
  passes = 0;
  n      = 0;
  fin    = 1'b0;
  while (!fin && (n < n_max)) begin
    exp_q.push_back(lane_out(tbl[p >> lg_cwf], lcfg));  // magnitude picks the entry
    p = step_ptr(c, p, pass_end);
    if (pass_end) passes++;
    fin = c.ben && !c.inf && pass_end && (passes >= int'(c.bpn));
    exp_last_q.push_back(fin);
    n++;
  end
endtask

`endif

// File: sim/lg_tb.sv
// logic pattern generator testbench
// random table and lane settings, stream predicted by a model,
// random back-pressure on the output stream
`timescale 1ns/10ps

module lg_tb;
  import lg_pkg::*;

  localparam int n_cont = 300;   // continuous beats before the stop

  // generator settings as {ben, inf, siz, off, ste, bpn}
  localparam gen_cfg_t cfg_cont = {1'b0, 1'b0, 16'hc800, 16'h1540, 16'h0180, 16'd0};
  localparam gen_cfg_t cfg_a    = {1'b1, 1'b0, 16'h2800, 16'h0300, 16'h0250, 16'd3};
  localparam gen_cfg_t cfg_b    = {1'b1, 1'b0, 16'h6400, 16'h0000, 16'h00c0, 16'd2};
  localparam gen_cfg_t cfg_c    = {1'b1, 1'b0, 16'h1000, 16'h0080, 16'h0100, 16'd1};

  logic             bus;
  logic             reset;
  cpu_req_t         reg_req;
  cpu_rsp_t         reg_rsp;
  cpu_req_t         tbl_req;
  cpu_rsp_t         tbl_rsp;
  logic [lg_tn-1:0] trg;
  pins_t            tdata;
  logic             tvalid;
  logic             tlast;
  logic             tready;
  logic             irq;

  integer    seed = 32'h1ade_dda1;
  beat_t     tbl [2**lg_cwm];    // shadow copy of the table
  lane_cfg_t lcfg;               // shadow copy of the lane controls
  pins_t     exp_q [$];          // predicted beats
  logic      exp_last_q [$];
  int        n_acc;              // accepted beats
  int        n_irq;              // irq high cycles
  bit        rand_rdy;           // random tready when set

  lg_top lg_top_i (
    .bus     (bus),
    .reset   (reset),
    .reg_req (reg_req),
    .reg_rsp (reg_rsp),
    .tbl_req (tbl_req),
    .tbl_rsp (tbl_rsp),
    .trg     (trg),
    .tdata   (tdata),
    .tvalid  (tvalid),
    .tlast   (tlast),
    .tready  (tready),
    .irq     (irq)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  `include "lg_tb_tasks.svh"

  initial begin
    bus = 1'b0;
    forever #20 bus = ~bus;  // 25 MHz
  end

  ////////////////////
  // watchdog
  ////////////////////

  initial begin : watchdog
    int total;
    total = n_cont + 3 + burst_len(cfg_a) + burst_len(cfg_b) + burst_len(cfg_c);
    repeat (total * 10 + 2000) @(posedge bus);
    abort_run("timeout, the stream did not finish in time");
  end

  ////////////////////
  // stream sink and scoreboard
  ////////////////////

  // tready and the accept decision come from one process on the falling edge
  initial begin : stream_sink
    logic rdy;
    tready = 1'b0;
    n_acc  = 0;
    n_irq  = 0;
    forever begin
      @(negedge bus);
      if (irq) n_irq++;
      rdy    = rand_rdy ? (($unsigned($random(seed)) % 10) < 7) : 1'b1;  // ~70 %
      tready = rdy;
      if (tvalid && rdy) begin       // taken on the next rising edge
        if (exp_q.size() == 0) begin
          abort_run("beat on the stream with no beat expected");
        end else begin
          check_pins("tdata", exp_q.pop_front(), tdata);
          check_last("tlast", exp_last_q.pop_front(), tlast);
          n_acc++;
        end
      end
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin : stimulus
    logic [31:0] rd;
    int          n;
    int          irq0;
    reset    = 1'b1;
    reg_req  = '0;
    tbl_req  = '0;
    trg      = '0;
    rand_rdy = 1'b0;
    repeat (5) @(negedge bus);
    reset = 1'b0;

    // registers and table readback, idle after reset
    check_reg(reg_ctl, 32'h0);
    check_reg(reg_sbn, 32'h0);
    reg_roundtrip(reg_trg, 32'h0000_000f);
    reg_roundtrip(reg_mod, 32'h0000_0003);
    reg_roundtrip(reg_siz, 32'h0000_ffff);
    reg_roundtrip(reg_off, 32'h0000_ffff);
    reg_roundtrip(reg_ste, 32'h0000_ffff);
    reg_roundtrip(reg_bpn, 32'h0000_ffff);
    reg_roundtrip(reg_oe0, 32'h0000_00ff);
    reg_roundtrip(reg_oe1, 32'h0000_00ff);
    reg_roundtrip(reg_msk, 32'h0000_00ff);
    reg_roundtrip(reg_val, 32'h0000_00ff);
    for (int i = 0; i < 2**lg_cwm; i++) begin
      tbl[i] = $random(seed);
      tbl_write(i, tbl[i]);
    end
    for (int i = 0; i < 2**lg_cwm; i++) begin
      tbl_read(i, rd);
      check_word($sformatf("tbl_rsp.rdata[%0d]", i), tbl[i], rd);
    end

    // continuous run, fractional step with wrap, then stop
    set_lanes();
    load_cfg(cfg_cont);
    predict(cfg_cont, n_cont + 10, n);
    start_sw();
    wait_beats(n_cont);
    reg_write(reg_ctl, 32'h2);       // stop
    @(posedge bus);
    n = n_acc;
    idle_cycles(20);
    if (n_acc - n > 3) abort_run("more than three beats came out after stop");
    check_reg(reg_ctl, 32'h0);
    exp_q.delete();
    exp_last_q.delete();

    // finite burst, tready always high
    set_lanes();
    load_cfg(cfg_a);
    predict(cfg_a, 1 << 20, n);
    irq0 = n_irq;
    start_sw();
    finish_burst(cfg_a, irq0);

    // finite burst under random back-pressure
    set_lanes();
    load_cfg(cfg_b);
    predict(cfg_b, 1 << 20, n);
    irq0 = n_irq;
    @(posedge bus);
    rand_rdy = 1'b1;
    start_sw();
    finish_burst(cfg_b, irq0);
    @(posedge bus);
    rand_rdy = 1'b0;

    // external triggers, masked bit first
    set_lanes();
    load_cfg(cfg_c);
    reg_write(reg_trg, 32'h5);
    reg_write(reg_ctl, 32'h1);       // arm
    pulse_trg(4'b0010);
    idle_cycles(8);
    @(negedge bus);
    if (tvalid !== 1'b0) abort_run("masked trigger started the stream");
    check_reg(reg_ctl, 32'h2);       // still armed
    predict(cfg_c, 1 << 20, n);
    irq0 = n_irq;
    pulse_trg(4'b0100);
    finish_burst(cfg_c, irq0);

    $display("Test passed");
    $finish;
  end

endmodule : lg_tb

// File: design/lg_top.sv
// logic pattern generator top
// registers, table, sequencer, pin lanes and stream stage
`timescale 1ns/10ps

module lg_top (
  input  logic                      bus,
  input  logic                      reset,
  input  lg_pkg::cpu_req_t          reg_req,
  output lg_pkg::cpu_rsp_t          reg_rsp,
  input  lg_pkg::cpu_req_t          tbl_req,
  output lg_pkg::cpu_rsp_t          tbl_rsp,
  input  logic [lg_pkg::lg_tn-1:0]  trg,
  output lg_pkg::pins_t             tdata,
  output logic                      tvalid,
  output logic                      tlast,
  input  logic                      tready,
  output logic                      irq
);
  import lg_pkg::*;

  gen_cfg_t          gen_cfg;
  lane_cfg_t         lane_cfg;
  ctl_t              ctl;
  sts_t              sts;
  logic [lg_cwn-1:0] sts_bpn;
  logic [lg_tn-1:0]  trg_msk;
  seq_item_t         item;
  logic              issue;
  logic              advance;   // whole pipe moves this cycle
  logic              last_acc;
  beat_t             rd_data;
  pins_t             pins;

  lg_regs lg_regs_i (
    .bus      (bus),
    .reset    (reset),
    .reg_req  (reg_req),
    .reg_rsp  (reg_rsp),
    .sts      (sts),
    .sts_bpn  (sts_bpn),
    .last_acc (last_acc),
    .gen_cfg  (gen_cfg),
    .lane_cfg (lane_cfg),
    .ctl      (ctl),
    .trg_msk  (trg_msk),
    .irq      (irq)
  );

  lg_table lg_table_i (
    .bus     (bus),
    .tbl_req (tbl_req),
    .tbl_rsp (tbl_rsp),
    .rd_adr  (item.adr),
    .rd_en   (advance),
    .rd_data (rd_data)
  );

  lg_sequencer lg_sequencer_i (
    .bus     (bus),
    .reset   (reset),
    .gen_cfg (gen_cfg),
    .ctl     (ctl),
    .trg     (trg),
    .trg_msk (trg_msk),
    .advance (advance),
    .item    (item),
    .issue   (issue),
    .sts     (sts),
    .sts_bpn (sts_bpn)
  );

  // one lane per sample of the beat
  for (genvar i = 0; i < lg_dn; i++) begin : g_lane
    lg_pin_lane lg_pin_lane_i (
      .bus      (bus),
      .reset    (reset),
      .advance  (advance),
      .smp      (rd_data[i]),
      .lane_cfg (lane_cfg),
      .pin      (pins[i])
    );
  end

  lg_stream_out lg_stream_out_i (
    .bus      (bus),
    .reset    (reset),
    .issue    (issue),
    .last_in  (item.last),
    .pins     (pins),
    .tready   (tready),
    .advance  (advance),
    .tdata    (tdata),
    .tvalid   (tvalid),
    .tlast    (tlast),
    .last_acc (last_acc)
  );

endmodule : lg_top

// File: design/lg_stream_out.sv
// stream output stage
// carries valid/last beside the table and lane registers,
// drives the valid/ready stream and the pipeline advance
`timescale 1ns/10ps

module lg_stream_out (
  input  logic           bus,
  input  logic           reset,
  input  logic           issue,
  input  logic           last_in,
  input  lg_pkg::pins_t  pins,
  input  logic           tready,
  output logic           advance,
  output lg_pkg::pins_t  tdata,
  output logic           tvalid,
  output logic           tlast,
  output logic           last_acc
);
  import lg_pkg::*;

  logic v1;  // valid at table output
  logic l1;  // last at table output

  // pipe moves when the output slot is empty or taken
  assign advance = tready | ~tvalid;

  ////////////////////
  // valid/last pipe
  ////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      v1     <= 1'b0;
      l1     <= 1'b0;
      tvalid <= 1'b0;
      tlast  <= 1'b0;
    end else if (advance) begin
      v1     <= issue;            // lines up with table read
      l1     <= issue & last_in;
      tvalid <= v1;               // lines up with lane registers
      tlast  <= l1;
    end
  end

  assign tdata    = pins;                     // lane registers hold the beat
  assign last_acc = tvalid & tready & tlast;  // burst end handed over

  // stalled beat must not change
  beat_hold: assert property (
    @(posedge bus) disable iff (reset)
    tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tlast)
  ) else $error("beat changed under back-pressure");

endmodule : lg_stream_out

// File: design/lg_pin_lane.sv
// pin lane
// mask and polarity on one sample, output enable per bit, registered
`timescale 1ns/10ps

module lg_pin_lane (
  input  logic               bus,
  input  logic               reset,
  input  logic               advance,
  input  lg_pkg::sample_t    smp,
  input  lg_pkg::lane_cfg_t  lane_cfg,
  output lg_pkg::pin_t       pin
);
  import lg_pkg::*;

  sample_t o_nxt;

  assign o_nxt = lane_cfg.val ^ (lane_cfg.msk & smp);  // masked, then polarity

  always_ff @(posedge bus) begin
    if (reset) begin
      pin <= '0;  // drivers off after reset
    end else if (advance) begin
      pin.o <= o_nxt;
      pin.e <= (lane_cfg.oe1 & o_nxt) | (lane_cfg.oe0 & ~o_nxt);  // per bit select
    end
  end

endmodule : lg_pin_lane

// File: design/lg_sequencer.sv
// logic generator sequencer
// arm/trigger/stop FSM, fixed point read pointer with wrap,
// burst pass counting and the last flag
`timescale 1ns/10ps

module lg_sequencer (
  input  logic                       bus,
  input  logic                       reset,
  input  lg_pkg::gen_cfg_t           gen_cfg,
  input  lg_pkg::ctl_t               ctl,
  input  logic [lg_pkg::lg_tn-1:0]   trg,
  input  logic [lg_pkg::lg_tn-1:0]   trg_msk,
  input  logic                       advance,
  output lg_pkg::seq_item_t          item,
  output logic                       issue,
  output lg_pkg::sts_t               sts,
  output logic [lg_pkg::lg_cwn-1:0]  sts_bpn
);
  import lg_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_armed,
    st_run
  } state_t;

  state_t            state;
  logic              trig;      // trigger condition
  logic [lg_cw-1:0]  ptr;       // fixed point read pointer
  logic [lg_cw:0]    sum;       // extra bit keeps the carry
  logic              wrap;      // end of a table pass
  logic [lg_cw-1:0]  ptr_nxt;
  logic [lg_cwn-1:0] cnt_nxt;
  logic              fin;       // this item ends the burst

  ////////////////////
  // pointer math
  ////////////////////

  assign trig    = ctl.swt | (|(trg & trg_msk));  // sw or any enabled ext trigger
  assign sum     = {1'b0, ptr} + {1'b0, gen_cfg.ste};
  assign wrap    = sum >= {1'b0, gen_cfg.siz};
  assign ptr_nxt = wrap ? lg_cw'(sum - {1'b0, gen_cfg.siz}) : sum[lg_cw-1:0];
  assign cnt_nxt = sts_bpn + 1'b1;

  // finite burst ends on the wrap that completes pass bpn
  assign fin = gen_cfg.ben & ~gen_cfg.inf & wrap & (cnt_nxt >= gen_cfg.bpn);

  assign issue     = (state == st_run) & advance;
  assign item.adr  = ptr[lg_cw-1:lg_cwf];  // magnitude only
  assign item.last = fin;

  assign sts.armed   = (state == st_armed);
  assign sts.running = (state == st_run);

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      state   <= st_idle;
      sts_bpn <= '0;
    end else if (ctl.stp) begin
      state <= st_idle;  // stop wins over everything
    end else begin
      case (state)
        st_idle: if (ctl.str) state <= st_armed;
        st_armed: begin
          if (trig) begin
            state   <= st_run;
            sts_bpn <= '0;     // new burst
          end
        end
        st_run: begin
          if (advance) begin
            if (wrap) sts_bpn <= cnt_nxt;  // one more pass done
            if (fin)  state   <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // pointer loads the phase on trigger, steps on each issue
  always_ff @(posedge bus) begin
    if ((state == st_armed) && trig) ptr <= gen_cfg.off;
    else if (issue)                  ptr <= ptr_nxt;
  end

  // issued items carry a loaded pointer and a known last flag
  item_known: assert property (
    @(posedge bus) disable iff (reset) issue |-> !$isunknown(item)
  ) else $error("issued item has unknown bits");

endmodule : lg_sequencer

// File: design/lg_table.sv
// waveform table
// cpu port for write and readback, registered read port for the sequencer
`timescale 1ns/10ps

module lg_table (
  input  logic                       bus,
  input  lg_pkg::cpu_req_t           tbl_req,
  output lg_pkg::cpu_rsp_t           tbl_rsp,
  input  logic [lg_pkg::lg_cwm-1:0]  rd_adr,
  input  logic                       rd_en,
  output lg_pkg::beat_t              rd_data
);
  import lg_pkg::*;

  beat_t mem [2**lg_cwm];  // one beat per entry

  logic [lg_cwm-1:0] cpu_adr;

  assign cpu_adr = tbl_req.addr[lg_cwm-1:0];  // word index

  ////////////////////
  // cpu side
  ////////////////////

  always_ff @(posedge bus) begin
    if (tbl_req.wen) mem[cpu_adr] <= beat_t'(tbl_req.wdata);
    tbl_rsp.rdata <= 32'(mem[cpu_adr]);
    tbl_rsp.ack   <= tbl_req.wen | tbl_req.ren;  // follows the request by one cycle
  end

  ////////////////////
  // sequencer side
  ////////////////////

  always_ff @(posedge bus) begin
    if (rd_en) rd_data <= mem[rd_adr];  // holds while the pipe stalls
  end

endmodule : lg_table

// File: design/lg_regs.sv
// logic generator register block
// config and status registers, control strobes and the burst interrupt
`timescale 1ns/10ps

module lg_regs (
  input  logic                        bus,
  input  logic                        reset,
  input  lg_pkg::cpu_req_t            reg_req,
  output lg_pkg::cpu_rsp_t            reg_rsp,
  input  lg_pkg::sts_t                sts,
  input  logic [lg_pkg::lg_cwn-1:0]   sts_bpn,
  input  logic                        last_acc,
  output lg_pkg::gen_cfg_t            gen_cfg,
  output lg_pkg::lane_cfg_t           lane_cfg,
  output lg_pkg::ctl_t                ctl,
  output logic [lg_pkg::lg_tn-1:0]    trg_msk,
  output logic                        irq
);
  import lg_pkg::*;

  logic [lg_baw-1:0] adr;    // byte offset inside the register window
  logic              ack;
  logic [32-1:0]     rdata;

  assign adr = reg_req.addr[lg_baw-1:0];

  ////////////////////
  // bus handshake
  ////////////////////

  always_ff @(posedge bus) begin
    if (reset) ack <= 1'b0;
    else       ack <= reg_req.wen | reg_req.ren;  // every request, one cycle later
  end

  assign reg_rsp.ack   = ack;
  assign reg_rsp.rdata = rdata;

  ////////////////////
  // write side
  ////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      gen_cfg  <= '0;
      lane_cfg <= '0;
      trg_msk  <= '0;
    end else if (reg_req.wen) begin
      case (adr)
        reg_trg: trg_msk <= reg_req.wdata[lg_tn-1:0];
        reg_mod: begin
          gen_cfg.ben <= reg_req.wdata[0];
          gen_cfg.inf <= reg_req.wdata[1];
        end
        reg_siz: gen_cfg.siz  <= reg_req.wdata[lg_cw-1:0];
        reg_off: gen_cfg.off  <= reg_req.wdata[lg_cw-1:0];
        reg_ste: gen_cfg.ste  <= reg_req.wdata[lg_cw-1:0];
        reg_bpn: gen_cfg.bpn  <= reg_req.wdata[lg_cwn-1:0];
        reg_oe0: lane_cfg.oe0 <= reg_req.wdata[lg_dw-1:0];
        reg_oe1: lane_cfg.oe1 <= reg_req.wdata[lg_dw-1:0];
        reg_msk: lane_cfg.msk <= reg_req.wdata[lg_dw-1:0];
        reg_val: lane_cfg.val <= reg_req.wdata[lg_dw-1:0];
        default: ;  // control and status handled elsewhere
      endcase
    end
  end

  // control strobes, high for a single cycle after the write
  always_ff @(posedge bus) begin
    if (reset) begin
      ctl <= '0;
    end else begin
      ctl.str <= reg_req.wen & (adr == reg_ctl) & reg_req.wdata[0];
      ctl.stp <= reg_req.wen & (adr == reg_ctl) & reg_req.wdata[1];
      ctl.swt <= reg_req.wen & (adr == reg_ctl) & reg_req.wdata[2];
    end
  end

  ////////////////////
  // read side
  ////////////////////

  always_ff @(posedge bus) begin
    if (reg_req.ren) begin
      case (adr)
        reg_ctl: rdata <= 32'(sts);
        reg_trg: rdata <= 32'(trg_msk);
        reg_mod: rdata <= {30'd0, gen_cfg.inf, gen_cfg.ben};
        reg_siz: rdata <= 32'(gen_cfg.siz);
        reg_off: rdata <= 32'(gen_cfg.off);
        reg_ste: rdata <= 32'(gen_cfg.ste);
        reg_bpn: rdata <= 32'(gen_cfg.bpn);
        reg_sbn: rdata <= 32'(sts_bpn);   // passes done in current burst
        reg_oe0: rdata <= 32'(lane_cfg.oe0);
        reg_oe1: rdata <= 32'(lane_cfg.oe1);
        reg_msk: rdata <= 32'(lane_cfg.msk);
        reg_val: rdata <= 32'(lane_cfg.val);
        default: rdata <= '0;             // holes read as zero
      endcase
    end
  end

  // burst done interrupt
  always_ff @(posedge bus) begin
    if (reset) irq <= 1'b0;
    else       irq <= last_acc;
  end

  // a request is a read or a write, never both
  req_one_kind: assert property (
    @(posedge bus) disable iff (reset) !(reg_req.wen && reg_req.ren)
  ) else $error("read and write requested together");

endmodule : lg_regs

// File: design/lg_pkg.sv
// logic pattern generator package
// sizes, register offsets and the shared bus, stream and lane types

package lg_pkg;

  ////////////////////
  // sizes
  ////////////////////

  localparam int unsigned lg_dn  = 4;              // lanes per beat
  localparam int unsigned lg_dw  = 8;              // bits per lane sample
  localparam int unsigned lg_cwm = 8;              // pointer magnitude, 256 table entries
  localparam int unsigned lg_cwf = 8;              // pointer fraction
  localparam int unsigned lg_cw  = lg_cwm + lg_cwf;
  localparam int unsigned lg_cwn = 16;             // burst period counter
  localparam int unsigned lg_tn  = 4;              // external trigger inputs
  localparam int unsigned lg_baw = 7;              // register byte address bits
  localparam int unsigned lg_aw  = lg_cwm;         // bus address, table word index fits too

  ////////////////////
  // register offsets
  ////////////////////

  localparam logic [lg_baw-1:0] reg_ctl = 7'h00;   // strobes on write, sts_t on read
  localparam logic [lg_baw-1:0] reg_trg = 7'h08;   // trigger mask
  localparam logic [lg_baw-1:0] reg_mod = 7'h10;   // {inf, ben}
  localparam logic [lg_baw-1:0] reg_siz = 7'h14;
  localparam logic [lg_baw-1:0] reg_off = 7'h18;
  localparam logic [lg_baw-1:0] reg_ste = 7'h1c;
  localparam logic [lg_baw-1:0] reg_bpn = 7'h2c;
  localparam logic [lg_baw-1:0] reg_sbn = 7'h34;   // burst count status, read only
  localparam logic [lg_baw-1:0] reg_oe0 = 7'h40;
  localparam logic [lg_baw-1:0] reg_oe1 = 7'h44;
  localparam logic [lg_baw-1:0] reg_msk = 7'h48;
  localparam logic [lg_baw-1:0] reg_val = 7'h4c;

  ////////////////////
  // data types
  ////////////////////

  typedef logic [lg_dw-1:0] sample_t;
  typedef sample_t [lg_dn-1:0] beat_t;             // one table word

  typedef struct packed {
    sample_t o;  // output value
    sample_t e;  // output enable
  } pin_t;

  typedef pin_t [lg_dn-1:0] pins_t;

  // cpu bus, one cycle request, ack one cycle later
  typedef struct packed {
    logic             wen;
    logic             ren;
    logic [lg_aw-1:0] addr;
    logic [32-1:0]    wdata;
  } cpu_req_t;

  typedef struct packed {
    logic          ack;
    logic [32-1:0] rdata;
  } cpu_rsp_t;

  typedef struct packed {
    sample_t oe0;  // enable where output is 0
    sample_t oe1;  // enable where output is 1
    sample_t msk;
    sample_t val;  // polarity
  } lane_cfg_t;

  typedef struct packed {
    logic              ben;  // burst enable
    logic              inf;  // infinite burst
    logic [lg_cw-1:0]  siz;  // table size, fixed point
    logic [lg_cw-1:0]  off;  // start offset (phase)
    logic [lg_cw-1:0]  ste;  // step (frequency)
    logic [lg_cwn-1:0] bpn;  // passes per burst
  } gen_cfg_t;

  typedef struct packed {
    logic str;  // arm
    logic stp;  // stop
    logic swt;  // software trigger
  } ctl_t;

  typedef struct packed {
    logic armed;
    logic running;
  } sts_t;

  typedef struct packed {
    logic [lg_cwm-1:0] adr;   // table address
    logic              last;  // final item of a burst
  } seq_item_t;

endpackage : lg_pkg
